//--- calc_ctrl.sv
// AXI4-Lite slave, register decode and command walk
// One write and one read in flight at a time; wstrb is ignored
// Element access and command writes while busy answer SLVERR
// A host element read takes read port A for one cycle and stalls the walk
`timescale 1ns/1ns
`include "matrix_defines.svh"

module calc_ctrl import matrix_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,
  input  logic [`AXI_ADDR_W-1:0] s_axil_awaddr,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,
  input  logic [`AXI_DATA_W-1:0] s_axil_wdata,
  input  logic [3:0]             s_axil_wstrb,
  output logic                   s_axil_bvalid,
  input  logic                   s_axil_bready,
  output logic [1:0]             s_axil_bresp,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,
  input  logic [`AXI_ADDR_W-1:0] s_axil_araddr,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready,
  output logic [`AXI_DATA_W-1:0] s_axil_rdata,
  output logic [1:0]             s_axil_rresp,
  store_if.ctrl                  sif,
  output logic                   issue_valid,
  output op_t                    issue_op,
  output logic [`ELEM_W-1:0]     issue_scalar,
  output elem_addr_t             issue_dst,
  input  logic                   alu_idle
);

  axil_addr_u             aw_addr;
  axil_addr_u             ar_addr;
  logic                   wr_hs;
  logic                   ar_hs;
  logic                   wr_is_cmd;
  logic                   cmd_accept;
  logic                   wr_accept_next;
  logic [1:0]             wr_resp;
  logic [1:0]             ar_resp;
  logic [`AXI_DATA_W-1:0] reg_rdata;
  logic                   busy;
  logic                   err;
  logic                   walking;
  logic [`AXI_DATA_W-1:0] cmd_q;
  op_t                    cmd_op;
  logic [IDX_W-1:0]       row_q;
  logic [IDX_W-1:0]       col_q;
  logic [IDX_W-1:0]       dst_rows_m1;
  logic [IDX_W-1:0]       dst_cols_m1;
  logic [IDX_W-1:0]       a_row;
  logic [IDX_W-1:0]       a_col;
  logic                   rd_s1;
  logic                   rd_s2;
  logic                   rd_elem;
  logic [1:0]             rd_resp;
  logic [`AXI_DATA_W-1:0] rd_data;
  elem_addr_t             rd_addr;
  logic                   host_rd_port;

  // ==========================================================================
  // Address decode and responses
  // ==========================================================================
  assign aw_addr    = s_axil_awaddr;
  assign ar_addr    = s_axil_araddr;
  assign wr_hs      = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
  assign ar_hs      = s_axil_arready && s_axil_arvalid;
  assign wr_is_cmd  = !aw_addr.regs.space && (aw_addr.regs.index == `REG_CMD);
  assign cmd_accept = wr_hs && wr_is_cmd && !busy;

  always_comb begin
    wr_resp = RESP_OKAY;
    if (aw_addr.elem.space || wr_is_cmd) begin
      if (busy) wr_resp = RESP_SLVERR;
    end else begin
      // Status is read only
      wr_resp = RESP_SLVERR;
    end
  end

  always_comb begin
    ar_resp   = RESP_OKAY;
    reg_rdata = '0;
    if (ar_addr.elem.space) begin
      if (busy) ar_resp = RESP_SLVERR;
    end else if (ar_addr.regs.index == `REG_CMD) begin
      reg_rdata = cmd_q;
    end else if (ar_addr.regs.index == `REG_STATUS) begin
      reg_rdata[`STATUS_BUSY_BIT] = busy;
      reg_rdata[`STATUS_ERR_BIT]  = err;
    end else begin
      ar_resp = RESP_SLVERR;
    end
  end

  // Host element writes go straight to the store on the handshake
  assign sif.host_wr_en   = wr_hs && aw_addr.elem.space && !busy;
  assign sif.host_wr_addr = {aw_addr.elem.slot, aw_addr.elem.row, aw_addr.elem.col};
  assign sif.host_wr_data = s_axil_wdata[`ELEM_W-1:0];

  // ==========================================================================
  // Write channel
  // ==========================================================================
  assign wr_accept_next = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid &&
                          !s_axil_awready;

  always_ff @(posedge clk) begin
    if (reset) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_bvalid  <= 1'b0;
    end else begin
      s_axil_awready <= wr_accept_next;
      s_axil_wready  <= wr_accept_next;
      if (wr_hs) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) s_axil_bresp <= wr_resp;
  end

  // ==========================================================================
  // Read channel, two stages to cover the store latency
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
      rd_s1          <= 1'b0;
      rd_s2          <= 1'b0;
    end else begin
      rd_s1 <= ar_hs;
      rd_s2 <= rd_s1;
      if (ar_hs) begin
        s_axil_arready <= 1'b0;
      end else if (!rd_s1 && !rd_s2 && (!s_axil_rvalid || s_axil_rready)) begin
        s_axil_arready <= 1'b1;
      end
      if (rd_s2) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_elem <= ar_addr.elem.space && !busy;
      rd_resp <= ar_resp;
      rd_data <= reg_rdata;
      rd_addr <= {ar_addr.elem.slot, ar_addr.elem.row, ar_addr.elem.col};
    end
    if (rd_s2) begin
      s_axil_rresp <= rd_resp;
      // Elements are sign extended to the bus width
      s_axil_rdata <= rd_elem ?
        {{(`AXI_DATA_W-`ELEM_W){sif.rd_a_data[`ELEM_W-1]}}, sif.rd_a_data} : rd_data;
    end
  end

  // ==========================================================================
  // Command walk over the destination, row major
  // ==========================================================================
  assign cmd_op      = op_t'(cmd_q[`CMD_OP_LSB +: OP_W]);
  assign dst_rows_m1 = (cmd_op == OP_TRANSPOSE) ? cmd_q[`CMD_COLS_LSB +: IDX_W] :
                                                  cmd_q[`CMD_ROWS_LSB +: IDX_W];
  assign dst_cols_m1 = (cmd_op == OP_TRANSPOSE) ? cmd_q[`CMD_ROWS_LSB +: IDX_W] :
                                                  cmd_q[`CMD_COLS_LSB +: IDX_W];
  // Transpose reads A at the swapped index
  assign a_row = (cmd_op == OP_TRANSPOSE) ? col_q : row_q;
  assign a_col = (cmd_op == OP_TRANSPOSE) ? row_q : col_q;

  assign host_rd_port  = rd_s1 && rd_elem;
  assign issue_valid   = walking && !host_rd_port;
  assign issue_op      = cmd_op;
  assign issue_scalar  = cmd_q[`CMD_SCALAR_LSB +: `ELEM_W];
  assign issue_dst     = {cmd_q[`CMD_DST_LSB +: SLOT_W], row_q, col_q};
  assign sif.rd_a_addr = host_rd_port ? rd_addr : {cmd_q[`CMD_SRC_A_LSB +: SLOT_W], a_row, a_col};
  assign sif.rd_b_addr = {cmd_q[`CMD_SRC_B_LSB +: SLOT_W], row_q, col_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      walking <= 1'b0;
      err     <= 1'b0;
      cmd_q   <= '0;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      if (cmd_accept) begin
        cmd_q   <= s_axil_wdata;
        busy    <= 1'b1;
        walking <= 1'b1;
        row_q   <= '0;
        col_q   <= '0;
      end else begin
        if (issue_valid) begin
          if (col_q == dst_cols_m1) begin
            col_q <= '0;
            if (row_q == dst_rows_m1) begin
              walking <= 1'b0;
            end else begin
              row_q <= row_q + 1'b1;
            end
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        // Wait for the last results to land in the store
        if (busy && !walking && alu_idle) busy <= 1'b0;
      end
      if ((wr_hs && wr_resp == RESP_SLVERR) || (ar_hs && ar_resp == RESP_SLVERR)) begin
        err <= 1'b1;
      end else if (cmd_accept) begin
        err <= 1'b0;
      end
    end
  end

  // Read data comes back two cycles after the address handshake
  a_rvalid_after_ar : assert property (@(posedge clk) disable iff (reset)
    $rose(s_axil_rvalid) |-> $past(ar_hs, 3));

  a_issue_only_busy : assert property (@(posedge clk) disable iff (reset)
    issue_valid |-> busy);

endmodule

//--- matrix_alu.sv
// Two stage element pipeline behind the store read ports
// Stage one lines up the issue fields with the read data
// Stage two computes and writes one result per cycle, no back-pressure
// Arithmetic wraps modulo 2^ELEM_W
`timescale 1ns/1ns
`include "matrix_defines.svh"

module matrix_alu import matrix_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               issue_valid,
  input  op_t                issue_op,
  input  logic [`ELEM_W-1:0] issue_scalar,
  input  elem_addr_t         issue_dst,
  store_if.alu               sif,
  output logic               alu_idle
);

  logic               s1_valid;
  op_t                s1_op;
  logic [`ELEM_W-1:0] s1_scalar;
  elem_addr_t         s1_dst;
  logic [`ELEM_W-1:0] result;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid      <= 1'b0;
      sif.res_wr_en <= 1'b0;
    end else begin
      s1_valid      <= issue_valid;
      sif.res_wr_en <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op           <= issue_op;
    s1_scalar       <= issue_scalar;
    s1_dst          <= issue_dst;
    sif.res_wr_addr <= s1_dst;
    sif.res_wr_data <= result;
  end

  always_comb begin
    case (s1_op)
      OP_ADD:   result = sif.rd_a_data + sif.rd_b_data;
      OP_SUB:   result = sif.rd_a_data - sif.rd_b_data;
      // Low half of the product
      OP_SCALE: result = sif.rd_a_data * s1_scalar;
      default:  result = sif.rd_a_data;
    endcase
  end

  assign alu_idle = !s1_valid && !sif.res_wr_en;

  // Each issued element reaches the store write port two cycles later
  a_issue_to_write : assert property (@(posedge clk) disable iff (reset)
    sif.res_wr_en == $past(issue_valid, 2));

endmodule

//--- matrix_calc_stim.txt
# Columns, hex: W addr data resp | R addr expected-data expected-resp | P polls status
# resp 0 is OKAY and 2 is SLVERR
# Source A in slot 0
W 800 00000005 0
W 808 00007fff 0
W 810 0000fffe 0
W 818 00000011 0
W 820 00001234 0
W 828 00008000 0
W 830 00000003 0
W 838 00000022 0
W 848 00000007 0
# Source B in slot 1
W 880 00000003 0
W 888 00000001 0
W 890 00000002 0
W 8a0 00000034 0
W 8a8 00000001 0
W 8b0 00000010 0
R 808 00007fff 0
R 810 fffffffe 0
R 828 ffff8000 0
R 8a0 00000034 0
# ADD 2x3, slot 0 plus slot 1 into slot 2
W 000 00000990 0
P
R 908 ffff8000 0
R 910 00000000 0
R 920 00001268 0
R 930 00000013 0
R 938 00000000 0
# SUB 2x3 into slot 3
W 000 000009d1 0
P
R 980 00000002 0
R 990 fffffffc 0
R 9a8 00007fff 0
R 9b0 fffffff3 0
# SCALE 3x3 of slot 0 by -3 into slot 2
W 000 0fffda82 0
P
R 900 fffffff1 0
R 908 ffff8003 0
R 928 ffff8000 0
R 948 ffffffeb 0
# TRANSPOSE 2x4 of slot 0 into slot 3
W 000 00000dc3 0
P
R 9e0 00000011 0
R 9e8 00000022 0
R 9a0 00007fff 0
R 988 00001234 0
R 9c8 00000003 0
# 4x4 ADD, then element and command access while busy
W 000 00000f90 0
W 800 00001111 2
W 000 000009d1 2
R 808 00000000 2
P
R 004 00000002 0
R 800 00000005 0
R 000 00000f90 0
R 948 00000007 0
# A good command clears the error bit, an unknown register sets it again
W 000 00000dc3 0
P
R 004 00000000 0
R 00c 00000000 2
R 004 00000002 0

//--- matrix_calc_top.f
+incdir+.
matrix_pkg.sv
store_if.sv
matrix_store.sv
matrix_alu.sv
calc_ctrl.sv
matrix_calc_top.sv
tb_matrix_calc.sv

//--- matrix_calc_top.sv
// Matrix calculator core behind a single AXI4-Lite slave port
// Write strobes are not supported and every write is treated as a full word
`timescale 1ns/1ns
`include "matrix_defines.svh"

module matrix_calc_top import matrix_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,
  input  logic [`AXI_ADDR_W-1:0] s_axil_awaddr,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,
  input  logic [`AXI_DATA_W-1:0] s_axil_wdata,
  input  logic [3:0]             s_axil_wstrb,
  output logic                   s_axil_bvalid,
  input  logic                   s_axil_bready,
  output logic [1:0]             s_axil_bresp,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,
  input  logic [`AXI_ADDR_W-1:0] s_axil_araddr,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready,
  output logic [`AXI_DATA_W-1:0] s_axil_rdata,
  output logic [1:0]             s_axil_rresp
);

  // Issue stream from the controller to the ALU
  logic               issue_valid;
  op_t                issue_op;
  logic [`ELEM_W-1:0] issue_scalar;
  elem_addr_t         issue_dst;
  logic               alu_idle;

  store_if sif ();

  calc_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .sif            (sif.ctrl),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_scalar   (issue_scalar),
    .issue_dst      (issue_dst),
    .alu_idle       (alu_idle)
  );

  matrix_store u_store (
    .clk   (clk),
    .reset (reset),
    .sif   (sif.store)
  );

  matrix_alu u_alu (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_scalar (issue_scalar),
    .issue_dst    (issue_dst),
    .sif          (sif.alu),
    .alu_idle     (alu_idle)
  );

endmodule

//--- matrix_defines.svh
// Sizes, register map and command word layout for the matrix calculator
// Slot and index widths are derived from MAT_SLOTS and MAT_DIM in matrix_pkg
// Both must stay powers of two for the packed element address to work
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

`define MAT_SLOTS        4
`define MAT_DIM          4
`define ELEM_W           16
`define AXI_ADDR_W       12
`define AXI_DATA_W       32

// Register indices in the register space
`define REG_CMD          3'd0
`define REG_STATUS       3'd1

// Command word fields, lsb positions
`define CMD_OP_LSB       0
`define CMD_SRC_A_LSB    2
`define CMD_SRC_B_LSB    4
`define CMD_DST_LSB      6
`define CMD_ROWS_LSB     8
`define CMD_COLS_LSB     10
`define CMD_SCALAR_LSB   12

`define STATUS_BUSY_BIT  0
`define STATUS_ERR_BIT   1

`endif

//--- matrix_pkg.sv
// Types shared by the matrix calculator blocks
// The AXI address layout assumes four slots of at most 4 x 4 elements
`include "matrix_defines.svh"

package matrix_pkg;

  localparam int SLOT_W = $clog2(`MAT_SLOTS);
  localparam int IDX_W  = $clog2(`MAT_DIM);
  localparam int OP_W   = 2;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [OP_W-1:0] {
    OP_ADD       = 2'd0,
    OP_SUB       = 2'd1,
    OP_SCALE     = 2'd2,
    OP_TRANSPOSE = 2'd3
  } op_t;

  // Store address as {slot, row, col}
  typedef logic [SLOT_W+2*IDX_W-1:0] elem_addr_t;

  // Element space, selected by space = 1
  typedef struct packed {
    logic              space;
    logic [1:0]        pad_hi;
    logic [SLOT_W-1:0] slot;
    logic [IDX_W-1:0]  row;
    logic [IDX_W-1:0]  col;
    logic              pad_lo;
    logic [1:0]        byte_off;
  } elem_view_t;

  // Register space, selected by space = 0
  typedef struct packed {
    logic       space;
    logic [5:0] pad;
    logic [2:0] index;
    logic [1:0] byte_off;
  } reg_view_t;

  typedef union packed {
    elem_view_t elem;
    reg_view_t  regs;
  } axil_addr_u;

endpackage

//--- matrix_store.sv
// Element memory for all matrix slots, cleared to zero on reset
// Two registered read ports with one cycle of latency
// Host and result writes share the array and must not coincide
`timescale 1ns/1ns
`include "matrix_defines.svh"

module matrix_store import matrix_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  store_if.store sif
);

  // One entry per slot, row and column
  localparam int DEPTH = 2 ** $bits(elem_addr_t);

  logic [`ELEM_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (sif.host_wr_en) begin
        mem[sif.host_wr_addr] <= sif.host_wr_data;
      end
      if (sif.res_wr_en) begin
        mem[sif.res_wr_addr] <= sif.res_wr_data;
      end
    end
  end

  // Read ports
  always_ff @(posedge clk) begin
    sif.rd_a_data <= mem[sif.rd_a_addr];
    sif.rd_b_data <= mem[sif.rd_b_addr];
  end

  // Host writes are refused while a command runs
  a_one_writer : assert property (@(posedge clk) disable iff (reset)
    !(sif.host_wr_en && sif.res_wr_en));

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns \
  --top-module tb_matrix_calc -f matrix_calc_top.f

./obj_dir/Vtb_matrix_calc | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- store_if.sv
// Read and write ports of the element store
// Read data returns one cycle after the address is presented
`timescale 1ns/1ns
`include "matrix_defines.svh"

interface store_if import matrix_pkg::*; ();

  // Read ports, A is shared between the host and the command walk
  elem_addr_t         rd_a_addr;
  elem_addr_t         rd_b_addr;
  logic [`ELEM_W-1:0] rd_a_data;
  logic [`ELEM_W-1:0] rd_b_data;

  // Host element writes from the AXI side
  logic               host_wr_en;
  elem_addr_t         host_wr_addr;
  logic [`ELEM_W-1:0] host_wr_data;

  // Result writes from the ALU
  logic               res_wr_en;
  elem_addr_t         res_wr_addr;
  logic [`ELEM_W-1:0] res_wr_data;

  modport ctrl (output rd_a_addr, rd_b_addr, host_wr_en, host_wr_addr, host_wr_data,
                input  rd_a_data);
  modport alu  (output res_wr_en, res_wr_addr, res_wr_data,
                input  rd_a_data, rd_b_data);
  modport store (input  rd_a_addr, rd_b_addr, host_wr_en, host_wr_addr, host_wr_data,
                 input  res_wr_en, res_wr_addr, res_wr_data,
                 output rd_a_data, rd_b_data);

endinterface

//--- tb_matrix_calc.sv
// Replays matrix_calc_stim.txt against the calculator core over AXI4-Lite
// Stim file is read from the current directory, so run from the project root
// bready and rready are held back 0 or 1 cycles from an LFSR, which keeps
// three transactions inside the busy window of a 4 x 4 command
`timescale 1ns/1ns
`include "matrix_defines.svh"

module tb_matrix_calc;

  localparam int WAIT_LIMIT = 200;
  localparam int POLL_LIMIT = 100;
  localparam logic [`AXI_ADDR_W-1:0] STATUS_ADDR = `AXI_ADDR_W'(`REG_STATUS) << 2;

  logic                   clk;
  logic                   reset;
  logic                   s_axil_awvalid;
  logic                   s_axil_awready;
  logic [`AXI_ADDR_W-1:0] s_axil_awaddr;
  logic                   s_axil_wvalid;
  logic                   s_axil_wready;
  logic [`AXI_DATA_W-1:0] s_axil_wdata;
  logic [3:0]             s_axil_wstrb;
  logic                   s_axil_bvalid;
  logic                   s_axil_bready;
  logic [1:0]             s_axil_bresp;
  logic                   s_axil_arvalid;
  logic                   s_axil_arready;
  logic [`AXI_ADDR_W-1:0] s_axil_araddr;
  logic                   s_axil_rvalid;
  logic                   s_axil_rready;
  logic [`AXI_DATA_W-1:0] s_axil_rdata;
  logic [1:0]             s_axil_rresp;

  logic [15:0]            lfsr_state;
  int                     fd;
  int                     code;
  int                     done;
  int                     lines;
  logic [7:0]             kind;
  logic [8*128-1:0]       skip_line;
  logic [`AXI_ADDR_W-1:0] addr;
  logic [`AXI_DATA_W-1:0] data;
  logic [`AXI_DATA_W-1:0] got_data;
  logic [1:0]             exp_resp;
  logic [1:0]             got_resp;

  matrix_calc_top dut0 (.*);

  always #5 clk = ~clk;

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_delay(output int cycles);
    lfsr_state = lfsr_next(lfsr_state);
    cycles = lfsr_state[0] ? 1 : 0;
  endtask

  task automatic check_b_held(input logic [1:0] first_resp);
    assert (s_axil_bvalid && s_axil_bresp == first_resp) else
      report_failure($sformatf("error @ %0t ns: write response dropped or changed", $time));
  endtask

  task automatic check_r_held(input logic [31:0] first_data, input logic [1:0] first_resp);
    assert (s_axil_rvalid && s_axil_rdata == first_data && s_axil_rresp == first_resp) else
      report_failure($sformatf("error @ %0t ns: read response dropped or changed", $time));
  endtask

  task automatic write_word(input logic [11:0] wa, input logic [31:0] wd,
                            output logic [1:0] resp);
    int n;
    int hold;
    s_axil_awaddr  <= wa;
    s_axil_awvalid <= 1'b1;
    s_axil_wdata   <= wd;
    s_axil_wvalid  <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n = n + 1;
    end while (!s_axil_awready && n < WAIT_LIMIT);
    if (!s_axil_awready) report_failure("DUT never accepted the write address and data");
    // Address and data are accepted in the same cycle
    assert (s_axil_wready) else
      report_failure($sformatf("error @ %0t ns: wready low while awready high", $time));
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n = n + 1;
    end while (!s_axil_bvalid && n < WAIT_LIMIT);
    if (!s_axil_bvalid) report_failure("DUT never returned a write response");
    resp = s_axil_bresp;
    take_delay(hold);
    repeat (hold) begin
      @(posedge clk);
      check_b_held(resp);
    end
    s_axil_bready <= 1'b1;
    @(posedge clk);
    check_b_held(resp);
    s_axil_bready <= 1'b0;
    @(posedge clk);
    assert (!s_axil_bvalid) else
      report_failure($sformatf("error @ %0t ns: write response repeated", $time));
  endtask

  task automatic read_word(input logic [11:0] ra, output logic [31:0] rd,
                           output logic [1:0] resp);
    int n;
    int hold;
    s_axil_araddr  <= ra;
    s_axil_arvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n = n + 1;
    end while (!s_axil_arready && n < WAIT_LIMIT);
    if (!s_axil_arready) report_failure("DUT never accepted the read address");
    s_axil_arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n = n + 1;
    end while (!s_axil_rvalid && n < WAIT_LIMIT);
    if (!s_axil_rvalid) report_failure("DUT never returned read data");
    rd   = s_axil_rdata;
    resp = s_axil_rresp;
    take_delay(hold);
    repeat (hold) begin
      @(posedge clk);
      check_r_held(rd, resp);
    end
    s_axil_rready <= 1'b1;
    @(posedge clk);
    check_r_held(rd, resp);
    s_axil_rready <= 1'b0;
    @(posedge clk);
    assert (!s_axil_rvalid) else
      report_failure($sformatf("error @ %0t ns: read response repeated", $time));
  endtask

  task automatic poll_idle();
    int n;
    logic [31:0] st;
    logic [1:0]  resp;
    n = 0;
    do begin
      read_word(STATUS_ADDR, st, resp);
      n = n + 1;
      assert (resp == 2'b00) else
        report_failure($sformatf("error @ %0t ns: status read answered %0d", $time, resp));
    end while (st[`STATUS_BUSY_BIT] && n < POLL_LIMIT);
    if (st[`STATUS_BUSY_BIT]) report_failure("busy never cleared after a command");
  endtask

  // ==========================================================================
  // Stimulus replay
  // ==========================================================================
  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = 4'hf;
    s_axil_bready  = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr  = '0;
    s_axil_rready  = 1'b0;
    lfsr_state     = 16'd61226;
    done           = 0;
    lines          = 0;
    fd = $fopen("matrix_calc_stim.txt", "r");
    if (fd == 0) report_failure("cannot open matrix_calc_stim.txt");
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    while (done == 0) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1;
      end else if (kind == "#") begin
        code = $fgets(skip_line, fd);
      end else if (kind == "W") begin
        code = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
        if (code != 3) report_failure("malformed W line in the stimulus file");
        write_word(addr, data, got_resp);
        assert (got_resp == exp_resp) else
          report_failure($sformatf("error @ %0t ns: write 0x%03h resp %0d, expected %0d",
                                   $time, addr, got_resp, exp_resp));
        lines = lines + 1;
      end else if (kind == "R") begin
        code = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
        if (code != 3) report_failure("malformed R line in the stimulus file");
        read_word(addr, got_data, got_resp);
        assert (got_data == data && got_resp == exp_resp) else
          report_failure($sformatf(
            "error @ %0t ns: read 0x%03h gave 0x%08h/%0d, expected 0x%08h/%0d",
            $time, addr, got_data, got_resp, data, exp_resp));
        lines = lines + 1;
      end else if (kind == "P") begin
        poll_idle();
        lines = lines + 1;
      end else begin
        report_failure("unknown line type in the stimulus file");
      end
    end
    $fclose(fd);
    if (lines == 0) begin
      report_failure("stimulus file held no transactions");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
